/* source/srrip_pkg.sv */
// shared geometry, widths and types for the SRRIP cache tag path
// import with srrip_pkg::* in the module header wherever these are used

package srrip_pkg;

	// cache geometry
	// --------------------
	localparam int CACHE_BLOCK_CAPACITY = 16;                          // total blocks held
	localparam int CACHE_SET_SIZE       = 4;                           // ways per set
	localparam int BW_CACHE_CAPACITY    = $clog2(CACHE_BLOCK_CAPACITY); // block address width
	localparam int BW_GRP               = $clog2(CACHE_SET_SIZE);       // way index width
	localparam int BW_SET               = BW_CACHE_CAPACITY - BW_GRP;   // set index width
	localparam int N_SET                = 2**BW_SET;                    // number of sets
	localparam int TAG_BW               = 8;                           // requester tag width

	// re-reference prediction
	// --------------------
	localparam int SRRIP_BW = 2;                                       // bits per rrpv

	typedef logic [SRRIP_BW-1:0] rrpv_t;

	localparam rrpv_t RRPV_MAX   = rrpv_t'(2**SRRIP_BW - 1);           // distant re-reference
	localparam rrpv_t SRRIP_INIT = rrpv_t'(2**SRRIP_BW - 2);           // long re-reference on fill

	// address fields
	// --------------------
	typedef logic [BW_GRP-1:0]            way_t;
	typedef logic [BW_SET-1:0]            set_t;
	typedef logic [TAG_BW-1:0]            tag_t;
	typedef logic [BW_CACHE_CAPACITY-1:0] blk_addr_t; // {way, set}, set in the low bits

	// per-set replacement fsm
	typedef enum logic [1:0] {
		IDLE,   // waiting for a miss on this set
		SEARCH, // look for a way at RRPV_MAX
		AGE,    // nothing found so bump every way
		DONE    // victim valid on the outputs
	} srrip_state_e;

	// requester side fsm
	typedef enum logic [1:0] {
		READY,       // lookup on request, hit answered directly
		WAIT_VICTIM, // miss raised, policy is searching
		FILL         // tag written, response cycle
	} tag_state_e;

endpackage

/* source/srrip_line_controller.sv */
// SRRIP state for one cache set with one rrpv register per way
// a hit promotes its way and a miss runs a search/age loop until a victim shows up

`timescale 1ns/1ps

module srrip_line_controller
	import srrip_pkg::*;
(
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic enable_i, // this set is the one addressed
	input  logic hit_i,    // promote way addr_i
	input  logic miss_i,   // start a victim search
	input  way_t addr_i,   // way of the hit
	output logic done_o,   // one-cycle pulse with the victim on addr_o
	output way_t addr_o    // chosen victim way
);

	// state
	// --------------------
	srrip_state_e state_q;
	rrpv_t        rrpv_q [CACHE_SET_SIZE]; // one prediction per way
	way_t         victim_q;                // latched result of the search

	logic         found;      // some way already at RRPV_MAX
	way_t         victim_way; // lowest such way

	// victim search
	// --------------------
	// walk from the top way down so the lowest index wins
	always_comb begin
		found      = 1'b0;
		victim_way = '0;
		for (int w = CACHE_SET_SIZE-1; w >= 0; w--) begin
			if (rrpv_q[w] == RRPV_MAX) begin
				found      = 1'b1;
				victim_way = way_t'(w);
			end
		end
	end

	// fsm and rrpv update
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			for (int w = 0; w < CACHE_SET_SIZE; w++) begin
				rrpv_q[w] <= RRPV_MAX; // every way starts as distant
			end
		end else begin
			case (state_q)
				IDLE: begin
					if (enable_i && miss_i) begin
						state_q <= SEARCH; // search next cycle
					end
				end
				SEARCH: begin
					if (found) begin
						rrpv_q[victim_way] <= SRRIP_INIT; // incoming block gets long interval
						state_q            <= DONE;
					end else begin
						state_q <= AGE;
					end
				end
				AGE: begin
					// no way is at max here so the increment cannot wrap
					for (int w = 0; w < CACHE_SET_SIZE; w++) begin
						rrpv_q[w] <= rrpv_q[w] + rrpv_t'(1);
					end
					state_q <= SEARCH; // retry for at most RRPV_MAX rounds
				end
				DONE: begin
					state_q <= IDLE;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase

			// a hit predicts near-immediate re-reference
			if (enable_i && hit_i) begin
				rrpv_q[addr_i] <= '0;
			end
		end
	end

	// latched victim way
	always_ff @(posedge clock_i) begin
		if (state_q == SEARCH && found) begin
			victim_q <= victim_way;
		end
	end

	// outputs
	// --------------------
	assign done_o = (state_q == DONE); // single cycle pulse
	assign addr_o = victim_q;          // only meaningful with done_o

endmodule

/* source/n_set_cache_srrip_policy_controller.sv */
// routes hit and miss pulses to the per-set SRRIP line controllers
// set field of addr_i picks the controller, its answer comes back on done_o/addr_o

`timescale 1ns/1ps

module n_set_cache_srrip_policy_controller
	import srrip_pkg::*;
(
	input  logic      clock_i,
	input  logic      rst_n_i,
	input  logic      hit_i,  // promote {way, set} of addr_i
	input  logic      miss_i, // request a victim in the set of addr_i
	input  blk_addr_t addr_i, // held stable through a miss
	output logic      done_o, // pulse, victim valid
	output blk_addr_t addr_o  // {victim way, set}
);

	generate
		if (BW_SET != 0) begin : g_multi_set
			set_t             addr_set;           // set field, low bits
			way_t             addr_way;           // way field, high bits
			logic [N_SET-1:0] enable_bus;         // one-hot set select
			logic [N_SET-1:0] done_bus;           // per-set done pulses
			way_t             way_bus [N_SET];    // per-set victim ways
			logic             done_sel;
			way_t             way_sel;

			assign addr_set = addr_i[BW_SET-1:0];
			assign addr_way = addr_i[BW_CACHE_CAPACITY-1:BW_SET];

			// set decode
			// --------------------
			always_comb begin
				for (int s = 0; s < N_SET; s++) begin
					enable_bus[s] = (addr_set == set_t'(s));
				end
			end

			// pick the addressed set's answer, address is static during a miss
			always_comb begin
				done_sel = 1'b0;
				way_sel  = '0;
				for (int s = 0; s < N_SET; s++) begin
					if (addr_set == set_t'(s)) begin
						done_sel = done_bus[s];
						way_sel  = way_bus[s];
					end
				end
			end

			assign done_o = done_sel;
			assign addr_o = {way_sel, addr_set}; // same set, victim way

			// one controller per set
			for (genvar g = 0; g < N_SET; g++) begin : g_line
				srrip_line_controller i_line_controller (
					.clock_i  (clock_i),
					.rst_n_i  (rst_n_i),
					.enable_i (enable_bus[g]),
					.hit_i    (hit_i),   // fanned out, enable picks the set
					.miss_i   (miss_i),
					.addr_i   (addr_way),
					.done_o   (done_bus[g]),
					.addr_o   (way_bus[g])
				);
			end
		end else begin : g_single_set
			way_t victim_way; // whole address is the way

			srrip_line_controller i_line_controller (
				.clock_i  (clock_i),
				.rst_n_i  (rst_n_i),
				.enable_i (1'b1), // single set is always addressed
				.hit_i    (hit_i),
				.miss_i   (miss_i),
				.addr_i   (addr_i[BW_GRP-1:0]),
				.done_o   (done_o),
				.addr_o   (victim_way)
			);

			assign addr_o = blk_addr_t'(victim_way);
		end
	endgenerate

endmodule

/* source/cache_tag_store.sv */
// tag and valid arrays for the set-associative cache, with lookup and fill
// answers each requester strobe with a one-cycle response, hit or filled way

`timescale 1ns/1ps

module cache_tag_store
	import srrip_pkg::*;
(
	input  logic      clock_i,
	input  logic      rst_n_i,
	input  logic      req_i,      // one-cycle request strobe
	input  set_t      req_set_i,
	input  tag_t      req_tag_i,
	input  logic      done_i,     // policy victim ready
	input  blk_addr_t victim_i,   // {victim way, set}
	output logic      hit_o,      // pulse to promote
	output logic      miss_o,     // pulse to request a victim
	output blk_addr_t pol_addr_o, // address seen by the policy
	output logic      resp_o,     // one-cycle response
	output logic      resp_hit_o,
	output logic      busy_o,
	output way_t      resp_way_o
);

	// storage
	// --------------------
	tag_t                      tag_mem [N_SET][CACHE_SET_SIZE];
	logic [CACHE_SET_SIZE-1:0] valid_q [N_SET]; // per way, per set

	tag_state_e state_q;
	logic       hit_q;
	logic       miss_q;
	logic       resp_q;
	logic       busy_q;

	set_t       set_q;      // set of the request in flight
	tag_t       tag_q;      // tag to be written on fill
	blk_addr_t  pol_addr_q;
	logic       resp_hit_q;
	way_t       resp_way_q;

	logic       lookup_hit;
	way_t       lookup_way;
	way_t       victim_way;
	logic       accept;     // request taken this cycle
	logic       fill_en;    // victim arrived, write the tag

	// lookup
	// --------------------
	always_comb begin
		lookup_hit = 1'b0;
		lookup_way = '0;
		for (int w = CACHE_SET_SIZE-1; w >= 0; w--) begin
			if (valid_q[req_set_i][w] && (tag_mem[req_set_i][w] == req_tag_i)) begin
				lookup_hit = 1'b1;
				lookup_way = way_t'(w); // lowest matching way
			end
		end
	end

	assign victim_way = victim_i[BW_CACHE_CAPACITY-1:BW_SET];
	assign accept     = (state_q == READY) && !busy_q && req_i; // ignored while busy
	assign fill_en    = (state_q == WAIT_VICTIM) && done_i;

	// control
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			state_q <= READY;
			hit_q   <= 1'b0;
			miss_q  <= 1'b0;
			resp_q  <= 1'b0;
			busy_q  <= 1'b0;
			for (int s = 0; s < N_SET; s++) begin
				valid_q[s] <= '0; // cache starts empty
			end
		end else begin
			hit_q  <= 1'b0; // pulses default low
			miss_q <= 1'b0;
			resp_q <= 1'b0;
			case (state_q)
				READY: begin
					if (busy_q) begin
						busy_q <= 1'b0; // hit response cycle ends here
					end else if (accept) begin
						busy_q <= 1'b1;
						if (lookup_hit) begin
							hit_q  <= 1'b1;
							resp_q <= 1'b1; // hit answered next cycle
						end else begin
							miss_q  <= 1'b1;
							state_q <= WAIT_VICTIM;
						end
					end
				end
				WAIT_VICTIM: begin
					if (fill_en) begin
						valid_q[set_q][victim_way] <= 1'b1;
						resp_q                     <= 1'b1;
						state_q                    <= FILL;
					end
				end
				FILL: begin
					busy_q  <= 1'b0; // response is out this cycle
					state_q <= READY;
				end
				default: begin
					state_q <= READY;
				end
			endcase
		end
	end

	// payload and tag array
	always_ff @(posedge clock_i) begin
		if (accept) begin
			set_q      <= req_set_i;
			tag_q      <= req_tag_i;
			pol_addr_q <= {lookup_way, req_set_i}; // way field only used on a hit
			resp_hit_q <= lookup_hit;
			resp_way_q <= lookup_way;
		end
		if (fill_en) begin
			tag_mem[set_q][victim_way] <= tag_q;
			resp_hit_q                 <= 1'b0;
			resp_way_q                 <= victim_way;
		end
	end

	// outputs
	// --------------------
	assign hit_o      = hit_q;
	assign miss_o     = miss_q;
	assign pol_addr_o = pol_addr_q; // stable until done_i
	assign resp_o     = resp_q;
	assign resp_hit_o = resp_hit_q;
	assign resp_way_o = resp_way_q;
	assign busy_o     = busy_q;

endmodule

/* source/srrip_cache_top.sv */
// top of the cache tag path, tag store plus SRRIP replacement policy
// requester drives req_*, reads back resp_* and holds off while busy_o is high

`timescale 1ns/1ps

module srrip_cache_top
	import srrip_pkg::*;
(
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic req_i,      // request strobe
	input  set_t req_set_i,
	input  tag_t req_tag_i,
	output logic resp_o,     // response pulse
	output logic resp_hit_o,
	output way_t resp_way_o, // hit way or filled way
	output logic busy_o
);

	// tag store to policy
	// --------------------
	logic      pol_hit;
	logic      pol_miss;
	blk_addr_t pol_addr;

	// policy to tag store
	logic      pol_done;
	blk_addr_t pol_victim;

	cache_tag_store i_tag_store (
		.clock_i    (clock_i),
		.rst_n_i    (rst_n_i),
		.req_i      (req_i),
		.req_set_i  (req_set_i),
		.req_tag_i  (req_tag_i),
		.done_i     (pol_done),
		.victim_i   (pol_victim),
		.hit_o      (pol_hit),
		.miss_o     (pol_miss),
		.pol_addr_o (pol_addr),
		.resp_o     (resp_o),
		.resp_hit_o (resp_hit_o),
		.busy_o     (busy_o),
		.resp_way_o (resp_way_o)
	);

	n_set_cache_srrip_policy_controller i_policy (
		.clock_i (clock_i),
		.rst_n_i (rst_n_i),
		.hit_i   (pol_hit),
		.miss_i  (pol_miss),
		.addr_i  (pol_addr),
		.done_o  (pol_done),
		.addr_o  (pol_victim)
	);

endmodule

/* verif/srrip_cache_tb.sv */
// testbench for srrip_cache_top, applies a table of set/tag requests in a loop
// expected hit, way and latency come from a small SRRIP reference model kept here

`timescale 1ns/1ps

module srrip_cache_tb
	import srrip_pkg::*;
();

	// dut signals
	// --------------------
	logic clock_i;
	logic rst_n_i;
	logic req_i;
	set_t req_set_i;
	tag_t req_tag_i;
	logic resp_o;
	logic resp_hit_o;
	way_t resp_way_o;
	logic busy_o;

	// stimulus table, one entry per request
	set_t   tbl_set  [$];
	tag_t   tbl_tag  [$];
	logic   tbl_cold [$]; // entry is a cold fill, way follows reset order

	// reference model state
	tag_t   m_tag   [N_SET][CACHE_SET_SIZE];
	logic   m_valid [N_SET][CACHE_SET_SIZE];
	int     m_rrpv  [N_SET][CACHE_SET_SIZE];
	int     cold_cnt [N_SET]; // cold fills seen per set

	integer seed = 32'hd3fa;  // fixed seed for the tag stream
	int     n_errors;
	int     n_checks;
	int     cycle_cnt;
	int     cycle_limit;

	srrip_cache_top i_dut (
		.clock_i    (clock_i),
		.rst_n_i    (rst_n_i),
		.req_i      (req_i),
		.req_set_i  (req_set_i),
		.req_tag_i  (req_tag_i),
		.resp_o     (resp_o),
		.resp_hit_o (resp_hit_o),
		.resp_way_o (resp_way_o),
		.busy_o     (busy_o)
	);

	// clock and watchdog
	// --------------------
	always #50 clock_i = ~clock_i; // 100 ns period

	always @(posedge clock_i) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("run timed out after %0d cycles, a response never arrived", cycle_cnt);
			$display("Test failures found");
			$finish;
		end
	end

	// table and model helpers
	// --------------------
	task automatic add_entry(input set_t s, input tag_t t, input logic cold);
		tbl_set.push_back(s);
		tbl_tag.push_back(t);
		tbl_cold.push_back(cold);
	endtask

	// applies one access to the model, returns hit, way and aging rounds
	task automatic model_access(input int s, input tag_t t, output logic hit,
		output way_t way, output int ages);
		int w;
		int found;
		hit   = 1'b0;
		way   = '0;
		ages  = 0;
		found = -1;
		for (w = 0; w < CACHE_SET_SIZE; w++) begin
			if (m_valid[s][w] && m_tag[s][w] == t && found < 0)
				found = w; // lowest matching way
		end
		if (found >= 0) begin
			hit            = 1'b1;
			way            = way_t'(found);
			m_rrpv[s][found] = 0; // promote on hit
		end else begin
			while (found < 0) begin
				for (w = 0; w < CACHE_SET_SIZE; w++) begin
					if (m_rrpv[s][w] == int'(RRPV_MAX) && found < 0)
						found = w;
				end
				if (found < 0) begin
					for (w = 0; w < CACHE_SET_SIZE; w++)
						m_rrpv[s][w]++; // age the whole set
					ages++;
				end
			end
			way              = way_t'(found);
			m_rrpv[s][found] = int'(SRRIP_INIT);
			m_tag[s][found]  = t;
			m_valid[s][found] = 1'b1;
		end
	endtask

	// compare tasks
	// --------------------
	task automatic check_hit(input int idx, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH test %0d resp_hit_o: got 0x%h expected 0x%h", idx, got, exp);
		end
	endtask

	task automatic check_way(input int idx, input way_t got, input way_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH test %0d resp_way_o: got 0x%h expected 0x%h", idx, got, exp);
		end
	endtask

	task automatic check_latency(input int idx, input int got, input int exp);
		n_checks++;
		if (got != exp) begin
			n_errors++;
			$display("MISMATCH test %0d resp_o latency: got 0x%h expected 0x%h", idx, got, exp);
		end
	endtask

	// main sequence
	// --------------------
	initial begin
		logic exp_hit;
		way_t exp_way;
		int   ages;
		int   exp_lat;
		int   lat;
		int   err_before;
		logic busy_gap;
		clock_i   = 1'b0;
		rst_n_i   = 1'b0;
		req_i     = 1'b0;
		req_set_i = '0;
		req_tag_i = '0;
		n_errors  = 0;
		n_checks  = 0;
		cycle_cnt = 0;
		for (int s = 0; s < N_SET; s++) begin
			cold_cnt[s] = 0;
			for (int w = 0; w < CACHE_SET_SIZE; w++) begin
				m_valid[s][w] = 1'b0;
				m_tag[s][w]   = '0;
				m_rrpv[s][w]  = int'(RRPV_MAX); // reset state
			end
		end

		// cold fill of set 0, then hits on ways 0 and 2
		for (int i = 0; i < 4; i++)
			add_entry(2'd0, tag_t'(8'h10 + i), 1'b1);
		add_entry(2'd0, 8'h10, 1'b0);
		add_entry(2'd0, 8'h12, 1'b0);
		// set 1 traffic in between, same tags in another set
		for (int i = 0; i < 4; i++)
			add_entry(2'd1, tag_t'(8'h10 + i), 1'b1);
		add_entry(2'd1, 8'h11, 1'b0);
		add_entry(2'd0, 8'h20, 1'b0); // evicts way 1 after one aging round
		add_entry(2'd0, 8'h10, 1'b0); // set 0 hits unchanged
		add_entry(2'd0, 8'h20, 1'b0);
		add_entry(2'd1, 8'h30, 1'b0);
		// set 3 fully promoted, worst case aging
		for (int i = 0; i < 4; i++)
			add_entry(2'd3, tag_t'(8'h40 + i), 1'b1);
		for (int i = 0; i < 4; i++)
			add_entry(2'd3, tag_t'(8'h40 + i), 1'b0);
		add_entry(2'd3, 8'h50, 1'b0);
		// random tag stream into set 2
		for (int i = 0; i < 16; i++)
			add_entry(2'd2, tag_t'($random(seed)), 1'b0);

		cycle_limit = 10 + tbl_set.size() * 12; // reset plus worst case per entry

		repeat (10) @(posedge clock_i);
		@(negedge clock_i);
		rst_n_i = 1'b1;

		for (int i = 0; i < tbl_set.size(); i++) begin
			err_before = n_errors;
			model_access(int'(tbl_set[i]), tbl_tag[i], exp_hit, exp_way, ages);
			exp_lat = exp_hit ? 1 : 4 + 2 * ages; // miss, search, done, fill
			if (tbl_cold[i]) begin
				exp_hit = 1'b0;
				exp_way = way_t'(cold_cnt[tbl_set[i]]); // ways fill in index order
				cold_cnt[tbl_set[i]]++;
			end

			@(negedge clock_i);
			while (busy_o)
				@(negedge clock_i);
			req_i     = 1'b1;
			req_set_i = tbl_set[i];
			req_tag_i = tbl_tag[i];
			@(negedge clock_i);
			req_i    = 1'b0;
			lat      = 1;
			busy_gap = 1'b0;
			while (!resp_o) begin
				if (!busy_o)
					busy_gap = 1'b1;
				@(negedge clock_i);
				lat++;
			end
			if (busy_gap || !busy_o) begin
				n_errors++;
				$display("test %0d: busy_o went low before the response arrived", i);
			end

			check_hit(i, resp_hit_o, exp_hit);
			check_way(i, resp_way_o, exp_way);
			check_latency(i, lat, exp_lat);
			$display("test %0d set %0d tag 0x%h %s way %0d latency %0d %s", i,
				tbl_set[i], tbl_tag[i], exp_hit ? "hit" : "miss", exp_way, lat,
				(n_errors == err_before) ? "ok" : "FAILED");
		end

		$display("tests %0d, checks %0d, errors %0d", tbl_set.size(), n_checks, n_errors);
		if (n_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* all.f */
source/srrip_pkg.sv
source/srrip_line_controller.sv
source/n_set_cache_srrip_policy_controller.sv
source/cache_tag_store.sv
source/srrip_cache_top.sv
verif/srrip_cache_tb.sv
